// ==== source/vicPkg.sv ====
// Shared types and the register map of the display-window video block.
// Beam position is 11 bits across and 9 bits down, so frameLines must fit 9 bits.
`default_nettype none

package vicPkg;

	// ====================
	// Width types
	// ====================

	// Horizontal beam position in clocks from the start of a line
	typedef logic [10:0] rasterX_t;
	// Vertical beam position in lines from the start of a frame
	typedef logic [8:0] rasterY_t;
	// Palette index, converted to RGB further downstream
	typedef logic [3:0] color_t;

	// ====================
	// Structs
	// ====================

	// Mode bits that pick the display window
	typedef struct packed {
		logic den;
		logic rsel;
		logic csel;
		logic col80;
	} videoMode_t;

	// One output pixel with the beam position it belongs to
	typedef struct packed {
		color_t color;
		logic border;
		logic hSync;
		logic vSync;
		rasterX_t x;
		rasterY_t y;
	} pixel_t;

	// Host side of an APB transfer
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	// ====================
	// Register byte offsets
	// ====================

	localparam logic [7:0] regCtrl = 8'h00;
	localparam logic [7:0] regBorderColor = 8'h04;
	localparam logic [7:0] regBackColor = 8'h08;
	localparam logic [7:0] regRasterCmp = 8'h0C;
	localparam logic [7:0] regIrqStat = 8'h10;
	localparam logic [7:0] regRaster = 8'h14;

endpackage

`default_nettype wire

// ==== source/rasterTiming.sv ====
// Free-running beam counters, the time base of the whole video path.
// lineCycles must exceed 666, and frameLines must exceed 252 and fit 9 bits.
`timescale 1ns/1ps
`default_nettype none

module rasterTiming #(
	parameter int lineCycles = 840,
	parameter int frameLines = 263,
	parameter int hSyncStart = 700,
	parameter int hSyncLen = 64,
	parameter int vSyncLine = 260
) (
	input wire logic clk33,
	input wire logic rst,
	output vicPkg::rasterX_t x,
	output vicPkg::rasterY_t y,
	output logic hSync,
	output logic vSync
);

	import vicPkg::*;

	// ====================
	// Counter limits
	// ====================

	// Last clock of a line and last line of a frame
	localparam rasterX_t xLast = rasterX_t'(lineCycles - 1);
	localparam rasterY_t yLast = rasterY_t'(frameLines - 1);

	// Horizontal sync covers hSyncFirst up to but not including hSyncEnd
	localparam rasterX_t hSyncFirst = rasterX_t'(hSyncStart);
	localparam rasterX_t hSyncEnd = rasterX_t'(hSyncStart + hSyncLen);

	// Vertical sync is a single whole line
	localparam rasterY_t vSyncY = rasterY_t'(vSyncLine);

	// ====================
	// Beam counters
	// ====================

	// x steps every clock and y steps once per line, at the x wrap
	always_ff @(posedge clk33) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else if (x == xLast) begin
			x <= '0;
			// End of the frame returns the beam to the top line
			if (y == yLast) begin
				y <= '0;
			end else begin
				y <= y + 1'b1;
			end
		end else begin
			x <= x + 1'b1;
		end
	end

	// ====================
	// Sync decode
	// ====================

	// Both flags are plain decodes of the counters and carry no extra delay
	// Downstream blocks delay them together with the position
	assign hSync = (x >= hSyncFirst) && (x < hSyncEnd);
	assign vSync = (y == vSyncY);

endmodule

`default_nettype wire

// ==== source/borderUnit.sv ====
// Border decision for the current beam position, one clock of latency.
// Window limits are fixed and follow the classic 40/38 column, 25/24 row layout.
`timescale 1ns/1ps
`default_nettype none

module borderUnit (
	input wire logic clk33,
	input wire logic rst,
	input vicPkg::videoMode_t mode,
	input vicPkg::rasterX_t x,
	input vicPkg::rasterY_t y,
	output logic hBorder,
	output logic vBorder,
	output logic border
);

	import vicPkg::*;

	// ====================
	// Window limits
	// ====================

	// Rows, 25 row window with rsel set and 24 row window with it clear
	localparam rasterY_t yTopRs = 9'd51;
	localparam rasterY_t yBotRs = 9'd251;
	localparam rasterY_t yTopNr = 9'd55;
	localparam rasterY_t yBotNr = 9'd247;

	// Columns, left edge depends on csel only
	localparam rasterX_t xLeftCs = 11'd25;
	localparam rasterX_t xLeftNc = 11'd32;
	// Right edge depends on both csel and col80
	localparam rasterX_t xRight80Cs = 11'd665;
	localparam rasterX_t xRight80Nc = 11'd656;
	localparam rasterX_t xRight40Cs = 11'd345;
	localparam rasterX_t xRight40Nc = 11'd336;

	rasterX_t xLeft;
	rasterX_t xRight;
	rasterY_t yTop;
	rasterY_t yBot;
	logic hOpen;
	logic vOpen;

	// Pick the active window edges from the mode bits
	assign yTop = mode.rsel ? yTopRs : yTopNr;
	assign yBot = mode.rsel ? yBotRs : yBotNr;
	assign xLeft = mode.csel ? xLeftCs : xLeftNc;
	assign xRight = mode.col80 ? (mode.csel ? xRight80Cs : xRight80Nc)
		: (mode.csel ? xRight40Cs : xRight40Nc);

	// The window is open only with the display enabled
	assign vOpen = mode.den && (y >= yTop) && (y <= yBot);
	assign hOpen = mode.den && (x >= xLeft) && (x <= xRight);

	// Registered flags, the whole screen is border straight out of reset
	always_ff @(posedge clk33) begin
		if (rst) begin
			hBorder <= 1'b1;
			vBorder <= 1'b1;
		end else begin
			hBorder <= !hOpen;
			vBorder <= !vOpen;
		end
	end

	assign border = hBorder | vBorder;

endmodule

`default_nettype wire

// ==== source/pixelColor.sv ====
// Colour stage, one clock behind the border decision and two behind the beam.
// Hold rst for at least two clocks so the position delay stage is filled.
`timescale 1ns/1ps
`default_nettype none

module pixelColor (
	input wire logic clk33,
	input wire logic rst,
	input wire logic border,
	input vicPkg::color_t borderColor,
	input vicPkg::color_t backColor,
	input vicPkg::rasterX_t x,
	input vicPkg::rasterY_t y,
	input wire logic hSync,
	input wire logic vSync,
	output vicPkg::pixel_t pixel
);

	import vicPkg::*;

	// ====================
	// Alignment stage
	// ====================

	// Position and sync wait here one clock so they meet the border flag
	rasterX_t xDly;
	rasterY_t yDly;
	logic hSyncDly;
	logic vSyncDly;

	always_ff @(posedge clk33) begin
		xDly <= x;
		yDly <= y;
		if (rst) begin
			hSyncDly <= 1'b0;
			vSyncDly <= 1'b0;
		end else begin
			hSyncDly <= hSync;
			vSyncDly <= vSync;
		end
	end

	// ====================
	// Output register
	// ====================

	// Colour is still sent during sync, the encoder does its own blanking
	always_ff @(posedge clk33) begin
		if (rst) begin
			pixel <= '{color: '0, border: 1'b1, hSync: 1'b0, vSync: 1'b0, x: '0, y: '0};
		end else begin
			pixel.color <= border ? borderColor : backColor;
			pixel.border <= border;
			pixel.hSync <= hSyncDly;
			pixel.vSync <= vSyncDly;
			pixel.x <= xDly;
			pixel.y <= yDly;
		end
	end

endmodule

`default_nettype wire

// ==== source/videoRegs.sv ====
// APB register block with mode, colours, raster compare and interrupt status.
// pready is tied high; bad or unaligned offsets raise pslverr in the access phase.
`timescale 1ns/1ps
`default_nettype none

module videoRegs (
	input wire logic clk33,
	input wire logic rst,
	input vicPkg::apbReq_t apb,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input vicPkg::rasterY_t y,
	input vicPkg::rasterX_t x,
	output vicPkg::videoMode_t mode,
	output vicPkg::color_t borderColor,
	output vicPkg::color_t backColor,
	output logic irq
);

	import vicPkg::*;

	// ====================
	// Bus decode
	// ====================

	logic access;
	logic wrEn;
	logic addrErr;
	logic irqEn;
	logic irqStat;
	logic cmpHit;
	logic irqClr;
	rasterY_t rasterCmp;

	// A transfer is live in its access phase, every access completes at once
	assign access = apb.psel && apb.penable;
	assign pready = 1'b1;

	// Offsets past regRaster or off a word boundary are errors
	assign addrErr = (apb.paddr > regRaster) || (apb.paddr[1:0] != 2'b00);
	assign pslverr = access && addrErr;

	// Erroneous writes are dropped, they never match a register below
	assign wrEn = access && apb.pwrite && !addrErr;

	// ====================
	// Control and colour registers
	// ====================

	// Control layout, bit 0 den, 1 rsel, 2 csel, 3 col80, 4 irq enable
	always_ff @(posedge clk33) begin
		if (rst) begin
			mode <= '{den: 1'b1, rsel: 1'b1, csel: 1'b1, col80: 1'b0};
			irqEn <= 1'b0;
			borderColor <= '0;
			backColor <= '0;
			rasterCmp <= '0;
		end else if (wrEn) begin
			case (apb.paddr)
				regCtrl: begin
					mode <= '{den: apb.pwdata[0], rsel: apb.pwdata[1],
						csel: apb.pwdata[2], col80: apb.pwdata[3]};
					irqEn <= apb.pwdata[4];
				end
				regBorderColor: borderColor <= apb.pwdata[3:0];
				regBackColor: backColor <= apb.pwdata[3:0];
				regRasterCmp: rasterCmp <= apb.pwdata[8:0];
				// The live raster and the status register are not plain storage
				default: ;
			endcase
		end
	end

	// ====================
	// Raster interrupt
	// ====================

	// Hit when the beam sits at the first clock of the compare line
	assign cmpHit = (x == '0) && (y == rasterCmp);
	assign irqClr = wrEn && (apb.paddr == regIrqStat) && apb.pwdata[0];

	// Write 1 to clear, a hit on the same edge keeps the flag set
	always_ff @(posedge clk33) begin
		if (rst) begin
			irqStat <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (cmpHit) begin
				irqStat <= 1'b1;
			end else if (irqClr) begin
				irqStat <= 1'b0;
			end
			irq <= irqStat && irqEn;
		end
	end

	// ====================
	// Read mux
	// ====================

	// Unused bits and unknown offsets read as zero
	always_comb begin
		prdata = '0;
		case (apb.paddr)
			regCtrl: prdata[4:0] = {irqEn, mode.col80, mode.csel, mode.rsel, mode.den};
			regBorderColor: prdata[3:0] = borderColor;
			regBackColor: prdata[3:0] = backColor;
			regRasterCmp: prdata[8:0] = rasterCmp;
			regIrqStat: prdata[0] = irqStat;
			// Live beam line, writes to this offset are ignored
			regRaster: prdata[8:0] = y;
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/videoTop.sv ====
// Display-window video top level, pixel output trails the beam by two clocks.
// No character, bitmap or sprite fetch, the picture is border or background only.
`timescale 1ns/1ps
`default_nettype none

module videoTop #(
	parameter int lineCycles = 840,
	parameter int frameLines = 263,
	parameter int hSyncStart = 700,
	parameter int hSyncLen = 64,
	parameter int vSyncLine = 260
) (
	input wire logic clk33,
	input wire logic rst,
	input vicPkg::apbReq_t apb,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output vicPkg::pixel_t pixel,
	output logic irq
);

	import vicPkg::*;

	// ====================
	// Internal nets
	// ====================

	rasterX_t x;
	rasterY_t y;
	logic hSync;
	logic vSync;
	logic border;
	videoMode_t mode;
	color_t borderColor;
	color_t backColor;

	// Beam time base for every other block
	rasterTiming #(
		.lineCycles(lineCycles),
		.frameLines(frameLines),
		.hSyncStart(hSyncStart),
		.hSyncLen(hSyncLen),
		.vSyncLine(vSyncLine)
	) u_rasterTiming (
		.clk33(clk33), .rst(rst), .x(x), .y(y), .hSync(hSync), .vSync(vSync)
	);

	// Separate edge flags stay internal, only their OR goes on
	borderUnit u_borderUnit (
		.clk33(clk33), .rst(rst), .mode(mode), .x(x), .y(y),
		.hBorder(), .vBorder(), .border(border)
	);

	pixelColor u_pixelColor (
		.clk33(clk33), .rst(rst), .border(border),
		.borderColor(borderColor), .backColor(backColor),
		.x(x), .y(y), .hSync(hSync), .vSync(vSync), .pixel(pixel)
	);

	videoRegs u_videoRegs (
		.clk33(clk33), .rst(rst), .apb(apb),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.y(y), .x(x), .mode(mode),
		.borderColor(borderColor), .backColor(backColor), .irq(irq)
	);

endmodule

`default_nettype wire

// ==== verification/videoTb.sv ====
// Directed testbench for videoTop at the default 840 x 263 raster.
// Expected pixels, sync and interrupt timing come from the window and timing rules.
`timescale 1ns/1ps
`default_nettype none

module videoTb;

	import vicPkg::*;

	// ====================
	// Raster constants
	// ====================

	localparam int lineCycles = 840;
	localparam int frameLines = 263;
	localparam int frameCycles = lineCycles * frameLines;
	// Sixteen frames cover every test with room to spare
	localparam longint watchdogNs = 16 * longint'(frameCycles) * 20 + 100_000;

	logic clk33 = 1'b0;
	logic rst;
	apbReq_t apb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	pixel_t pixel;
	logic irq;
	// Pixel seen at the sampling point of the last APB read
	pixel_t readPixel;
	logic [31:0] lfsrState = 32'h5e4d_ec34;

	videoTop u_videoTop (
		.clk33(clk33), .rst(rst), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .pixel(pixel), .irq(irq)
	);

	always #10 clk33 = ~clk33;

	initial begin
		#(watchdogNs);
		stopRun("Timeout: the tests did not finish before the watchdog expired");
	end

	// ====================
	// Helpers
	// ====================

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportMismatch(input string msg);
		stopRun($sformatf("FAIL at %0t ns: %s", $time, msg));
	endtask

	// Feedback from taps 32, 22, 2 and 1 with one step for every bit handed out
	function automatic logic [31:0] lfsrBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Border rule from the 25/24 row window and the four column windows
	function automatic logic expectBorder(input videoMode_t m, input int px, input int py);
		int left;
		int right;
		logic inRows;
		left = m.csel ? 25 : 32;
		case ({m.col80, m.csel})
			2'b11: right = 665;
			2'b10: right = 656;
			2'b01: right = 345;
			default: right = 336;
		endcase
		inRows = m.rsel ? (py >= 51 && py <= 251) : (py >= 55 && py <= 247);
		return !(m.den && inRows && px >= left && px <= right);
	endfunction

	// The beam runs two clocks ahead of the pixel that leaves the top
	function automatic int beamLine(input pixel_t p);
		int bx;
		int by;
		bx = int'(p.x) + 2;
		by = int'(p.y);
		if (bx >= lineCycles) begin
			by = (by + 1) % frameLines;
		end
		return by;
	endfunction

	// Setup goes out on one falling edge and access on the next
	// The response is sampled 1 ns into the access phase
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk33);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk33);
		apb.penable = 1'b1;
		#1;
		assert (pready) else reportMismatch("pready low in the access phase");
		err = pslverr;
		@(negedge clk33);
		apb = '0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk33);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
		@(negedge clk33);
		apb.penable = 1'b1;
		#1;
		assert (pready) else reportMismatch("pready low in the access phase");
		data = prdata;
		err = pslverr;
		readPixel = pixel;
		@(negedge clk33);
		apb = '0;
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		apbWrite(addr, data, err);
		assert (!err) else reportMismatch($sformatf("pslverr on write to 0x%02h", addr));
	endtask

	task automatic expectRead(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		logic err;
		apbRead(addr, data, err);
		assert (!err && data == expected) else
			reportMismatch($sformatf("read 0x%02h gave %h err %0b, expected %h",
				addr, data, err, expected));
	endtask

	// Live line readback against the beam line derived from the output pixel
	task automatic checkRasterRead();
		logic [31:0] data;
		logic err;
		apbRead(regRaster, data, err);
		assert (!err && data < 32'd263 && int'(data) == beamLine(readPixel)) else
			reportMismatch($sformatf("raster read %0d, beam line %0d", data,
				beamLine(readPixel)));
	endtask

	task automatic setMode(input videoMode_t m, input logic irqEn);
		writeReg(regCtrl, {27'd0, irqEn, m.col80, m.csel, m.rsel, m.den});
	endtask

	task automatic pickColors(output color_t bc, output color_t kc);
		bc = color_t'(lfsrBits(4));
		kc = color_t'(lfsrBits(4));
		while (kc == bc) begin
			kc = color_t'(lfsrBits(4));
		end
		writeReg(regBorderColor, {28'd0, bc});
		writeReg(regBackColor, {28'd0, kc});
	endtask

	task automatic checkFrame(input videoMode_t m, input color_t bc, input color_t kc);
		logic expBorder;
		for (int n = 0; n < frameCycles; n++) begin
			@(negedge clk33);
			expBorder = expectBorder(m, int'(pixel.x), int'(pixel.y));
			assert (pixel.border == expBorder && pixel.color == (expBorder ? bc : kc)) else
				reportMismatch($sformatf("pixel (%0d,%0d) border %0b colour %h, expected %0b %h",
					pixel.x, pixel.y, pixel.border, pixel.color, expBorder,
					expBorder ? bc : kc));
		end
	endtask

	// Irq must rise within a frame while the beam is on the compare line
	task automatic waitIrq(input int cmpLine);
		int n;
		n = 0;
		while (!irq && n < frameCycles + lineCycles) begin
			@(negedge clk33);
			n++;
		end
		assert (irq) else stopRun("Timeout: the raster interrupt did not rise within a frame");
		assert (beamLine(pixel) == cmpLine) else
			reportMismatch($sformatf("irq rose on line %0d, compare line %0d",
				beamLine(pixel), cmpLine));
	endtask

	// ====================
	// Tests
	// ====================

	task automatic testRegisters();
		logic [31:0] data;
		logic err;
		expectRead(regCtrl, 32'h07);
		expectRead(regBorderColor, 32'h0);
		expectRead(regBackColor, 32'h0);
		expectRead(regRasterCmp, 32'h0);
		// Compare line 0 is hit at the first clock after reset
		expectRead(regIrqStat, 32'h1);
		assert (!irq) else reportMismatch("irq high with the enable clear");
		writeReg(regCtrl, 32'hffff_ffff);
		expectRead(regCtrl, 32'h1f);
		writeReg(regBorderColor, 32'hffff_ffff);
		expectRead(regBorderColor, 32'hf);
		writeReg(regBackColor, 32'hffff_ffff);
		expectRead(regBackColor, 32'hf);
		writeReg(regRasterCmp, 32'hffff_ffff);
		expectRead(regRasterCmp, 32'h1ff);
		// Line 511 never comes, so the flag stays clear
		writeReg(regIrqStat, 32'hffff_ffff);
		expectRead(regIrqStat, 32'h0);
		writeReg(regRaster, 32'hffff_ffff);
		checkRasterRead();
		apbRead(8'h18, data, err);
		assert (err && data == 32'h0) else reportMismatch("no pslverr on offset 0x18");
		apbWrite(8'h03, 32'h1, err);
		assert (err) else reportMismatch("no pslverr on offset 0x03");
	endtask

	task automatic testGeometry();
		videoMode_t m;
		color_t bc;
		color_t kc;
		for (int i = 0; i < 8; i++) begin
			m = '{den: 1'b1, rsel: i[0], csel: i[1], col80: i[2]};
			pickColors(bc, kc);
			setMode(m, 1'b0);
			repeat (2) @(negedge clk33);
			checkFrame(m, bc, kc);
		end
	endtask

	task automatic testDisplayOff();
		videoMode_t m;
		color_t bc;
		color_t kc;
		m = '{den: 1'b0, rsel: 1'b1, csel: 1'b1, col80: 1'b0};
		pickColors(bc, kc);
		setMode(m, 1'b0);
		repeat (2) @(negedge clk33);
		checkFrame(m, bc, kc);
	endtask

	task automatic testPositionSync();
		int px;
		int py;
		int ex;
		int ey;
		@(negedge clk33);
		px = int'(pixel.x);
		py = int'(pixel.y);
		for (int n = 0; n < frameCycles; n++) begin
			@(negedge clk33);
			ex = (px == lineCycles - 1) ? 0 : px + 1;
			ey = (px != lineCycles - 1) ? py : (py + 1) % frameLines;
			px = int'(pixel.x);
			py = int'(pixel.y);
			assert (px == ex && py == ey) else
				reportMismatch($sformatf("pixel at (%0d,%0d), expected (%0d,%0d)",
					px, py, ex, ey));
			assert (pixel.hSync == (px >= 700 && px <= 763) && pixel.vSync == (py == 260)) else
				reportMismatch($sformatf("sync %0b%0b wrong at (%0d,%0d)",
					pixel.hSync, pixel.vSync, px, py));
		end
		for (int i = 0; i < 8; i++) begin
			repeat (int'(lfsrBits(14))) @(negedge clk33);
			checkRasterRead();
		end
	endtask

	task automatic testRasterIrq();
		int cmpLine;
		cmpLine = int'(lfsrBits(9) % 32'd263);
		// Status is cleared before the enable so a stale hit cannot show on irq
		writeReg(regRasterCmp, 32'(cmpLine));
		writeReg(regIrqStat, 32'h1);
		writeReg(regCtrl, 32'h17);
		waitIrq(cmpLine);
		repeat (4 * lineCycles) begin
			@(negedge clk33);
			assert (irq) else reportMismatch("irq dropped before it was cleared");
		end
		writeReg(regIrqStat, 32'h1);
		@(negedge clk33);
		assert (!irq) else reportMismatch("irq still high after the status clear");
		waitIrq(cmpLine);
		// Status stays set and only the enable keeps irq low
		writeReg(regCtrl, 32'h07);
		repeat (2 * lineCycles) begin
			@(negedge clk33);
			assert (!irq) else reportMismatch("irq high with the enable clear");
		end
		expectRead(regIrqStat, 32'h1);
	endtask

	initial begin
		rst = 1'b1;
		apb = '0;
		repeat (2) @(negedge clk33);
		rst = 1'b0;
		testRegisters();
		testGeometry();
		testDisplayOff();
		testPositionSync();
		testRasterIrq();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/vicPkg.sv
source/rasterTiming.sv
source/borderUnit.sv
source/pixelColor.sv
source/videoRegs.sv
source/videoTop.sv
verification/videoTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module videoTb -Mdir obj_dir

# A fatal stop exits non-zero; the output search below decides the result
simOut=$(./obj_dir/VvideoTb 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -q "Simulation completed successfully"; then
	exit 0
fi
echo "Run did not report success"
exit 1
